// ==== Makefile ====
# Verilator build and run of the credit link endpoint testbench

TOP  := tb_serial_link_credit_endpoint
SRCS := $(wildcard source/*.sv) $(wildcard tb/*.sv) serial_link_credit_endpoint.f

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/V$(TOP): $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
	  -f serial_link_credit_endpoint.f -o V$(TOP)

run: obj_dir/V$(TOP) tb/credit_vectors.txt
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== serial_link_credit_endpoint.f ====
source/link_data_pkg.sv
source/link_ctrl_pkg.sv
source/credit_tx_gate.sv
source/rx_credit_fifo.sv
source/credit_return_counter.sv
source/serial_link_credit_endpoint.sv
tb/tb_serial_link_credit_endpoint.sv

// ==== source/credit_return_counter.sv ====
/*
 * credit return counter
 * turns receive FIFO pops into credits owed back to the peer and keeps the
 * outgoing count stable while a packet waits on the link
 */

`timescale 1ns/1ps

module credit_return_counter
  import link_data_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  // one pulse per entry drained from the receive FIFO
  input  logic    pop_strobe_i,
  // an outgoing packet transfers on this cycle
  input  logic    send_fire_i,
  // an outgoing packet is offered but the link is not ready
  input  logic    send_stall_i,
  // credits carried on the current outgoing packet
  output credit_t owed_credits_o
);

  credit_t owed_q, owed_d;
  credit_t shadow_q, shadow_d;
  credit_t pop_inc;

  assign pop_inc = credit_t'(pop_strobe_i);

  ////////////////////////////////////////////////////////////////////////////
  // owed and shadow counts
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    owed_d   = owed_q;
    shadow_d = shadow_q;
    if (send_fire_i) begin
      // the visible count has just left with the packet
      // what was gathered in the shadow during the wait now becomes visible
      owed_d   = shadow_q + pop_inc;
      shadow_d = '0;
    end else if (send_stall_i) begin
      // the outgoing field must not move while valid waits for ready
      // so pops are parked in the shadow count for now
      shadow_d = shadow_q + pop_inc;
    end else begin
      // no packet on the link, pops show up on the next cycle
      owed_d = owed_q + pop_inc;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owed_q   <= '0;
      shadow_q <= '0;
    end else begin
      owed_q   <= owed_d;
      shadow_q <= shadow_d;
    end
  end

  // the visible count rides on every outgoing packet
  assign owed_credits_o = owed_q;

endmodule

// ==== source/credit_tx_gate.sv ====
/*
 * transmit credit gate
 * lets local data out toward the peer only while credits are available and
 * forces credits-only packets once too many credits are owed to the peer
 */

`timescale 1ns/1ps

module credit_tx_gate
  import link_data_pkg::*;
  import link_ctrl_pkg::*;
#(
  parameter int NumCredits  = DEF_NUM_CREDITS,
  parameter int ForceThresh = DEF_FORCE_THRESH
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // local transmit stream
  input  logic     tx_valid_i,
  input  payload_t tx_data_i,
  output logic     tx_ready_o,
  // outgoing link handshake and packet fields
  output logic     link_valid_o,
  output payload_t link_data_o,
  output logic     link_cred_only_o,
  input  logic     link_ready_i,
  // credits returned by the peer on the incoming link
  input  logic     rx_credit_valid_i,
  input  credit_t  rx_credits_i,
  // credits owed to the peer, as carried on the current packet
  input  credit_t  owed_credits_i,
  // transfer pulse and stall level for the return counter
  output logic     send_fire_o,
  output logic     send_stall_o
);

  // every packet costs one credit, data or credits-only alike
  localparam credit_t PktCost = credit_t'(1);

  credit_t  avail_q, avail_d;
  tx_mode_e mode_q, mode_d;
  logic     cred_only;
  logic     can_send;
  logic     force_cred;
  logic     send_fire;

  assign cred_only = (mode_q == TX_CRED_ONLY);

  ////////////////////////////////////////////////////////////////////////////
  // packet gating
  ////////////////////////////////////////////////////////////////////////////

  // the last credit is only spent when credits also travel back with it
  // otherwise both ends could sit on zero credits with everything in flight
  assign can_send = (avail_q > PktCost) ||
                    ((avail_q == PktCost) && (owed_credits_i != '0));

  // a packet goes out for waiting local data or for a pending credits-only packet
  assign link_valid_o = can_send & (tx_valid_i | cred_only);

  // credits-only packets carry no payload so the data field is tied to zero
  assign link_data_o      = cred_only ? '0 : tx_data_i;
  assign link_cred_only_o = cred_only;

  // local data is only consumed by a data packet that actually transfers
  assign tx_ready_o = link_ready_i & link_valid_o & ~cred_only;

  assign send_fire    = link_valid_o & link_ready_i;
  assign send_fire_o  = send_fire;
  assign send_stall_o = link_valid_o & ~link_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // packet mode
  ////////////////////////////////////////////////////////////////////////////

  assign force_cred = (owed_credits_i >= credit_t'(ForceThresh));

  always_comb begin
    mode_d = mode_q;
    // switch only while nothing is offered on the link
    // changing the mode under a raised valid would alter the packet in flight
    if (force_cred && !link_valid_o && !(tx_valid_i && can_send)) begin
      mode_d = TX_CRED_ONLY;
    end else if (send_fire) begin
      // any transfer carries the owed credits away, so normal data resumes
      mode_d = TX_NORMAL;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // available credit counter
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    avail_d = avail_q;
    // credits come back from the peer on every incoming strobe
    if (rx_credit_valid_i) begin
      avail_d = avail_d + rx_credits_i;
    end
    // each outgoing packet takes one slot in the peer buffer
    if (send_fire) begin
      avail_d = avail_d - PktCost;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // the peer buffer starts out empty, so every credit is ours
      avail_q <= credit_t'(NumCredits);
      mode_q  <= TX_NORMAL;
    end else begin
      avail_q <= avail_d;
      mode_q  <= mode_d;
    end
  end

endmodule

// ==== source/link_ctrl_pkg.sv ====
/*
 * link control definitions
 * transmit packet mode and the default flow control constants
 */

package link_ctrl_pkg;

  // the transmitter either forwards local data or sends a credits-only packet
  typedef enum logic {
    TX_NORMAL    = 1'b0,
    TX_CRED_ONLY = 1'b1
  } tx_mode_e;

  // depth of the peer receive buffer, which is also the starting credit count
  parameter int DEF_NUM_CREDITS = 8;

  // owed credits at which a credits-only packet is forced out
  parameter int DEF_FORCE_THRESH = 4;

endpackage

// ==== source/link_data_pkg.sv ====
/*
 * link data types
 * widths of the payload word and of every credit count used across the
 * credit-based serial link endpoint
 */

package link_data_pkg;

  // width of one packet data word as it travels over the link
  parameter int DATA_WIDTH = 16;

  // a credit count must hold the full peer buffer depth
  // it must also hold the owed count plus whatever piles up in the shadow count
  parameter int CREDIT_WIDTH = 4;

  // one packet's data word
  typedef logic [DATA_WIDTH-1:0] payload_t;

  // any credit count, available, owed or shadowed
  typedef logic [CREDIT_WIDTH-1:0] credit_t;

endpackage

// ==== source/rx_credit_fifo.sv ====
/*
 * receive FIFO
 * circular buffer as deep as the credit count that holds payloads from the
 * peer and reports every entry drained by the local sink
 */

`timescale 1ns/1ps

module rx_credit_fifo
  import link_data_pkg::*;
#(
  parameter int NumCredits = 8
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // write side, fed straight from the incoming link
  input  logic     push_i,
  input  payload_t push_data_i,
  // read side toward the local sink
  output logic     rx_valid_o,
  output payload_t rx_data_o,
  input  logic     rx_ready_i,
  // one pulse per drained entry, later returned to the peer as a credit
  output logic     pop_strobe_o
);

  // pointers need at least one bit even for a single-entry buffer
  localparam int PtrWidth = (NumCredits > 1) ? $clog2(NumCredits) : 1;
  localparam int CntWidth = $clog2(NumCredits + 1);

  payload_t              mem [NumCredits];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [CntWidth-1:0]   count_q;
  logic                  full;
  logic                  push_ok;
  logic                  pop;

  assign full = (count_q == CntWidth'(NumCredits));

  // a peer that respects credits never hits a full buffer
  // a push that does arrive then is simply lost
  assign push_ok = push_i & ~full;

  assign rx_valid_o   = (count_q != '0);
  assign rx_data_o    = mem[rd_ptr_q];
  assign pop          = rx_valid_o & rx_ready_i;
  assign pop_strobe_o = pop;

  // storage holds payload only and needs no reset
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap explicitly since the depth need not be a power of two
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(NumCredits - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(NumCredits - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leave the fill level unchanged
      count_q <= count_q + CntWidth'(push_ok) - CntWidth'(pop);
    end
  end

endmodule

// ==== source/serial_link_credit_endpoint.sv ====
/*
 * credit-based serial link endpoint
 * one end of the link with a credit gated transmitter, a receive FIFO and
 * the counter that returns drained entries to the peer as credits
 */

`timescale 1ns/1ps

module serial_link_credit_endpoint
  import link_data_pkg::*;
  import link_ctrl_pkg::*;
#(
  parameter int NumCredits  = DEF_NUM_CREDITS,
  parameter int ForceThresh = DEF_FORCE_THRESH
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // local transmit stream
  input  logic     tx_valid_i,
  input  payload_t tx_data_i,
  output logic     tx_ready_o,
  // outgoing link toward the peer
  output logic     link_valid_o,
  output payload_t link_data_o,
  output credit_t  link_credits_o,
  output logic     link_cred_only_o,
  input  logic     link_ready_i,
  // incoming link from the peer, a strobe without back-pressure
  input  logic     link_valid_i,
  input  logic     link_cred_only_i,
  input  payload_t link_data_i,
  input  credit_t  link_credits_i,
  // local receive stream
  output logic     rx_valid_o,
  output payload_t rx_data_o,
  input  logic     rx_ready_i
);

  logic    send_fire;
  logic    send_stall;
  logic    pop_strobe;
  logic    fifo_push;
  credit_t owed_credits;

  // credits-only packets carry no payload and never occupy a FIFO slot
  assign fifo_push = link_valid_i & ~link_cred_only_i;

  // the owed count is exactly what goes out on the link
  assign link_credits_o = owed_credits;

  ////////////////////////////////////////////////////////////////////////////
  // transmit side
  ////////////////////////////////////////////////////////////////////////////

  credit_tx_gate #(
    .NumCredits  (NumCredits),
    .ForceThresh (ForceThresh)
  ) u_credit_tx_gate (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .tx_valid_i        (tx_valid_i),
    .tx_data_i         (tx_data_i),
    .tx_ready_o        (tx_ready_o),
    .link_valid_o      (link_valid_o),
    .link_data_o       (link_data_o),
    .link_cred_only_o  (link_cred_only_o),
    .link_ready_i      (link_ready_i),
    .rx_credit_valid_i (link_valid_i),
    .rx_credits_i      (link_credits_i),
    .owed_credits_i    (owed_credits),
    .send_fire_o       (send_fire),
    .send_stall_o      (send_stall)
  );

  ////////////////////////////////////////////////////////////////////////////
  // receive side
  ////////////////////////////////////////////////////////////////////////////

  // the buffer is sized so that every credit handed to the peer has a slot
  rx_credit_fifo #(
    .NumCredits (NumCredits)
  ) u_rx_credit_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (fifo_push),
    .push_data_i  (link_data_i),
    .rx_valid_o   (rx_valid_o),
    .rx_data_o    (rx_data_o),
    .rx_ready_i   (rx_ready_i),
    .pop_strobe_o (pop_strobe)
  );

  credit_return_counter u_credit_return_counter (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .pop_strobe_i   (pop_strobe),
    .send_fire_i    (send_fire),
    .send_stall_i   (send_stall),
    .owed_credits_o (owed_credits)
  );

endmodule

// ==== tb/credit_vectors.txt ====
# tag tx_valid tx_data link_ready link_valid link_credits link_cred_only link_data rx_ready
# values in hex, a link_ready of 2 draws a random ready bit
idle      0 0000 1 0 0 0 0000 0
burst     1 a001 1 0 0 0 0000 0
burst     1 a002 1 0 0 0 0000 0
burst     1 a003 1 0 0 0 0000 0
burst     1 a004 1 0 0 0 0000 0
burst     1 a005 1 0 0 0 0000 0
burst     1 a006 1 0 0 0 0000 0
burst     1 a007 1 0 0 0 0000 0
credstop  1 a008 1 0 0 0 0000 0
rxorder   1 a008 1 1 0 0 b001 0
rxorder   1 a008 1 1 0 0 b002 1
rxorder   1 a008 1 0 0 0 0000 1
credrx    0 0000 1 1 8 1 ffff 0
forcecred 0 0000 1 1 0 0 c001 0
forcecred 0 0000 1 1 0 0 c002 1
forcecred 0 0000 1 1 0 0 c003 1
forcecred 0 0000 1 0 0 0 0000 1
forcecred 0 0000 1 1 0 0 d001 0
forcecred 0 0000 1 1 0 0 d002 0
stall     1 e001 0 0 0 0 0000 1
stall     1 e001 0 0 0 0 0000 1
stall     1 e001 1 0 0 0 0000 0
stall     0 0000 1 0 0 0 0000 0
randrdy   1 f001 2 0 0 0 0000 0
randrdy   1 f001 2 0 0 0 0000 0
randrdy   1 f001 2 0 0 0 0000 0
randrdy   1 f001 1 0 0 0 0000 0
idle      0 0000 1 0 0 0 0000 0

// ==== tb/tb_serial_link_credit_endpoint.sv ====
/*
 * testbench for the credit-based serial link endpoint
 * replays one vector line per cycle and checks every output against a
 * reference model of the available, owed and shadow counts and the rx FIFO
 */

`timescale 1ns/1ps

module tb_serial_link_credit_endpoint
  import link_data_pkg::*;
();

  localparam int NumCredits  = 8;
  localparam int ForceThresh = 4;
  localparam int ClkPeriod   = 100;
  localparam int DriveDelay  = 10;
  localparam int CheckDelay  = 50;
  localparam int NumFields   = 8;

  logic     clk_i, rst_n_i;
  logic     tx_valid_i, tx_ready_o;
  payload_t tx_data_i;
  logic     link_valid_o, link_cred_only_o, link_ready_i;
  payload_t link_data_o;
  credit_t  link_credits_o;
  logic     link_valid_i, link_cred_only_i;
  payload_t link_data_i;
  credit_t  link_credits_i;
  logic     rx_valid_o, rx_ready_i;
  payload_t rx_data_o;

  // each vector is a tag plus NumFields numbers, flattened into field_q
  string tag_q[$];
  int    field_q[$];
  int    num_vecs;
  bit    vecs_loaded;
  int    seed;
  int    errors;

  // reference model of the endpoint
  int       m_avail, m_owed, m_shadow;
  logic     m_cred_mode, m_can_send, m_valid, m_prev_stall;
  payload_t m_data, m_prev_data;
  int       m_prev_credits;
  payload_t m_rxq[$];

  serial_link_credit_endpoint #(
    .NumCredits  (NumCredits),
    .ForceThresh (ForceThresh)
  ) u_serial_link_credit_endpoint (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .tx_valid_i (tx_valid_i), .tx_data_i (tx_data_i), .tx_ready_o (tx_ready_o),
    .link_valid_o (link_valid_o), .link_data_o (link_data_o),
    .link_credits_o (link_credits_o), .link_cred_only_o (link_cred_only_o),
    .link_ready_i (link_ready_i),
    .link_valid_i (link_valid_i), .link_cred_only_i (link_cred_only_i),
    .link_data_i (link_data_i), .link_credits_i (link_credits_i),
    .rx_valid_o (rx_valid_o), .rx_data_o (rx_data_o), .rx_ready_i (rx_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // vector file and error reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int    fd;
    int    n;
    string line;
    string tag;
    int    f [NumFields];
    fd = $fopen("tb/credit_vectors.txt", "r");
    if (fd == 0) begin
      $display("ERROR: the vector file tb/credit_vectors.txt could not be opened");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // lines starting with a hash describe the columns
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", tag,
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
        if (n == NumFields + 1) begin
          tag_q.push_back(tag);
          foreach (f[k]) field_q.push_back(f[k]);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic report_mismatch(input string name, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("FAIL %s: %s expected %0h actual %0h at %0t", name, field, exp, act, $time);
  endtask

  task automatic apply_vector(input int idx);
    int base;
    base = idx * NumFields;
    tx_valid_i       = (field_q[base] != 0);
    // an idle tx port carries the complement of its data column as junk
    // so a credits-only packet really has to clear the data field
    if (tx_valid_i) begin
      tx_data_i = payload_t'(field_q[base + 1]);
    end else begin
      tx_data_i = ~payload_t'(field_q[base + 1]);
    end
    // a ready code of 2 marks a stall phase with a random ready bit
    if (field_q[base + 2] == 2) begin
      link_ready_i = $random(seed) & 1;
    end else begin
      link_ready_i = (field_q[base + 2] != 0);
    end
    link_valid_i     = (field_q[base + 3] != 0);
    link_credits_i   = credit_t'(field_q[base + 4]);
    link_cred_only_i = (field_q[base + 5] != 0);
    link_data_i      = payload_t'(field_q[base + 6]);
    rx_ready_i       = (field_q[base + 7] != 0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_outputs(input string name);
    logic exp_tx_ready;
    // the last credit only goes out together with returned credits
    m_can_send   = (m_avail > 1) || ((m_avail == 1) && (m_owed != 0));
    m_valid      = m_can_send && (tx_valid_i || m_cred_mode);
    m_data       = m_cred_mode ? '0 : tx_data_i;
    exp_tx_ready = link_ready_i && m_valid && !m_cred_mode;
    if (link_valid_o !== m_valid) report_mismatch(name, "link_valid_o", m_valid, link_valid_o);
    if (link_cred_only_o !== m_cred_mode) begin
      report_mismatch(name, "link_cred_only_o", m_cred_mode, link_cred_only_o);
    end
    if (link_credits_o !== credit_t'(m_owed)) begin
      report_mismatch(name, "link_credits_o", m_owed, link_credits_o);
    end
    if (tx_ready_o !== exp_tx_ready) report_mismatch(name, "tx_ready_o", exp_tx_ready, tx_ready_o);
    if (m_valid && link_data_o !== m_data) begin
      report_mismatch(name, "link_data_o", m_data, link_data_o);
    end
    if (rx_valid_o !== (m_rxq.size() != 0)) begin
      report_mismatch(name, "rx_valid_o", m_rxq.size() != 0, rx_valid_o);
    end
    if (m_rxq.size() != 0 && rx_data_o !== m_rxq[0]) begin
      report_mismatch(name, "rx_data_o", m_rxq[0], rx_data_o);
    end
    // a packet waiting for ready keeps every field from the cycle before
    if (m_prev_stall && m_valid) begin
      if (link_data_o !== m_prev_data) begin
        report_mismatch(name, "held link_data_o", m_prev_data, link_data_o);
      end
      if (link_credits_o !== credit_t'(m_prev_credits)) begin
        report_mismatch(name, "held link_credits_o", m_prev_credits, link_credits_o);
      end
    end
  endtask

  task automatic advance_model();
    logic fire;
    logic stall;
    logic pop;
    logic push;
    fire  = m_valid && link_ready_i;
    stall = m_valid && !link_ready_i;
    pop   = (m_rxq.size() != 0) && rx_ready_i;
    push  = link_valid_i && !link_cred_only_i && (m_rxq.size() < NumCredits);
    m_prev_stall   = stall;
    m_prev_data    = m_data;
    m_prev_credits = m_owed;
    if ((m_owed >= ForceThresh) && !m_valid && !(tx_valid_i && m_can_send)) begin
      m_cred_mode = 1'b1;
    end else if (fire) begin
      m_cred_mode = 1'b0;
    end
    // pops seen during a stall wait in the shadow count until the transfer
    if (fire) begin
      m_owed   = m_shadow + int'(pop);
      m_shadow = 0;
    end else if (stall) begin
      m_shadow = m_shadow + int'(pop);
    end else begin
      m_owed = m_owed + int'(pop);
    end
    if (link_valid_i) m_avail = m_avail + int'(link_credits_i);
    if (fire) m_avail = m_avail - 1;
    if (pop) void'(m_rxq.pop_front());
    if (push) m_rxq.push_back(link_data_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus, watchdog and report
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed = 75;
    errors = 0;
    vecs_loaded = 1'b0;
    rst_n_i = 1'b0;
    tx_valid_i = 1'b0;
    tx_data_i = '0;
    link_ready_i = 1'b0;
    link_valid_i = 1'b0;
    link_cred_only_i = 1'b0;
    link_data_i = '0;
    link_credits_i = '0;
    rx_ready_i = 1'b0;
    m_avail = NumCredits;
    m_owed = 0;
    m_shadow = 0;
    m_cred_mode = 1'b0;
    m_prev_stall = 1'b0;
    m_data = '0;
    m_prev_data = '0;
    m_prev_credits = 0;
    load_vectors();
    num_vecs = tag_q.size();
    vecs_loaded = 1'b1;
    if (num_vecs == 0) begin
      $display("ERROR: no test vectors were read");
      errors++;
    end
    repeat (3) @(posedge clk_i);
    #(DriveDelay);
    rst_n_i = 1'b1;
    for (int i = 0; i < num_vecs; i++) begin
      @(posedge clk_i);
      #(DriveDelay);
      apply_vector(i);
      #(CheckDelay);
      check_outputs(tag_q[i]);
      advance_model();
    end
    $display("vectors: %0d, errors: %0d", num_vecs, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // the run may take twenty cycles per vector before it counts as hung
  initial begin
    wait (vecs_loaded);
    repeat (20 * (num_vecs + 1)) @(posedge clk_i);
    $display("ERROR: watchdog timeout, the vectors did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule
